// File: hw/mips_defines.svh
// MIPS core constants
// Widths, reset vector and fixed register numbers shared by the RTL

`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// Datapath and register index widths
`define MIPS_WORD_W 32
`define MIPS_REG_ADDR_W 5

// First fetch address after reset
`define MIPS_RESET_VECTOR 32'hBFC0_0000

// Register exported on register_v0
`define MIPS_REG_V0 5'd2

`define MIPS_WORD_BYTES 4

`endif

// File: hw/mips_isa_pkg.sv
// MIPS instruction set types
// Opcode and function encodings of the supported subset, plus field types

`include "mips_defines.svh"

package mips_isa_pkg;

	typedef logic [`MIPS_WORD_W-1:0] instr_t;
	typedef logic [`MIPS_REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [15:0] imm_t;

	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDIU   = 6'h09,
		OP_ANDI    = 6'h0c,
		OP_ORI     = 6'h0d,
		OP_XORI    = 6'h0e,
		OP_LUI     = 6'h0f,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2b
	} opcode_t;

	// SPECIAL function field
	typedef enum logic [5:0] {
		FN_JR   = 6'h08,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_SLTU = 6'h2b
	} funct_t;

endpackage

// File: hw/mips_pipe_pkg.sv
// Pipeline microarchitecture types
// Word type, ALU operations, forwarding selects and bus sequencer states

`include "mips_defines.svh"

package mips_pipe_pkg;

	typedef logic [`MIPS_WORD_W-1:0] word_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLTU,
		ALU_LUI
	} alu_op_t;

	// Operand source for execute
	typedef enum logic [1:0] {
		FWD_REG      = 2'd0,
		FWD_FROM_MEM = 2'd1,
		FWD_FROM_WB  = 2'd2
	} fwd_sel_t;

	typedef enum logic [1:0] {
		BUS_FETCH,
		BUS_DATA,
		BUS_STEP
	} bus_state_t;

endpackage

// File: hw/fetch_unit.sv
// Fetch stage
// Program counter, next-PC choice, halt detection and the fetch/decode register

`timescale 1ns/10ps

`include "mips_defines.svh"

module fetch_unit (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 advance,
	input  logic                 stall_front,
	input  mips_pipe_pkg::word_t fetched_instr,
	input  logic                 branch_taken,
	input  mips_pipe_pkg::word_t branch_target,
	output mips_pipe_pkg::word_t pc,
	output logic                 fetch_enabled,
	output mips_isa_pkg::instr_t instr_decode,
	output mips_pipe_pkg::word_t pc_plus4_decode,
	output logic                 halt_decode
);
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;

	word_t pc_plus4;
	logic  halted;

	assign pc_plus4 = pc + `MIPS_WORD_BYTES;
	assign fetch_enabled = !halted;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= `MIPS_RESET_VECTOR;
			halted <= 1'b0;
			instr_decode <= '0;
			halt_decode <= 1'b0;
		end else if (advance && !stall_front) begin
			pc <= branch_taken ? branch_target : pc_plus4;
			// JR to address zero ends the program
			if (branch_taken && branch_target == '0)
				halted <= 1'b1;
			// NOP carrying the halt marker once fetch is off
			instr_decode <= halted ? instr_t'(0) : instr_t'(fetched_instr);
			halt_decode <= halted;
		end
	end

	always_ff @(posedge clk) begin
		if (advance && !stall_front)
			pc_plus4_decode <= pc_plus4;
	end

endmodule

// File: hw/decode_stage.sv
// Decode stage
// Control decode, register file, branch resolution and the decode/execute register

`timescale 1ns/10ps

`include "mips_defines.svh"

module decode_stage (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    advance,
	input  logic                    bubble_execute,
	input  mips_isa_pkg::instr_t    instr_decode,
	input  mips_pipe_pkg::word_t    pc_plus4_decode,
	input  logic                    halt_decode,
	input  logic                    wb_write,
	input  mips_isa_pkg::reg_addr_t wb_dest,
	input  mips_pipe_pkg::word_t    wb_result,
	input  mips_pipe_pkg::word_t    mem_alu_result,
	input  logic                    fwd_a_decode,
	input  logic                    fwd_b_decode,
	output logic                    branch_taken,
	output mips_pipe_pkg::word_t    branch_target,
	output mips_isa_pkg::reg_addr_t rs_decode,
	output mips_isa_pkg::reg_addr_t rt_decode,
	output logic                    uses_rt_decode,
	output logic                    is_branch_decode,
	output mips_pipe_pkg::alu_op_t  ex_op,
	output mips_pipe_pkg::word_t    ex_a,
	output mips_pipe_pkg::word_t    ex_b,
	output mips_pipe_pkg::word_t    ex_imm,
	output logic                    ex_use_imm,
	output mips_isa_pkg::reg_addr_t ex_rs,
	output mips_isa_pkg::reg_addr_t ex_rt,
	output mips_isa_pkg::reg_addr_t ex_dest,
	output logic                    ex_reg_write,
	output logic                    ex_mem_read,
	output logic                    ex_mem_write,
	output logic                    ex_halt,
	output mips_pipe_pkg::word_t    register_v0
);
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;

	opcode_t   op;
	funct_t    funct;
	reg_addr_t rd;
	imm_t      imm;
	word_t     ext_imm;
	word_t     rd_a;
	word_t     rd_b;
	word_t     cmp_a;
	word_t     cmp_b;
	word_t     regs [32];

	alu_op_t   dec_op;
	reg_addr_t dec_dest;
	logic      dec_use_imm;
	logic      dec_zero_ext;
	logic      dec_reg_write;
	logic      dec_mem_read;
	logic      dec_mem_write;
	logic      is_beq;
	logic      is_bne;
	logic      is_jr;

	assign op = opcode_t'(instr_decode[31:26]);
	assign funct = funct_t'(instr_decode[5:0]);
	assign rs_decode = instr_decode[25:21];
	assign rt_decode = instr_decode[20:16];
	assign rd = instr_decode[15:11];
	assign imm = instr_decode[15:0];

	always_comb begin
		dec_op = ALU_ADD;
		dec_dest = (op == OP_SPECIAL) ? rd : rt_decode;
		dec_use_imm = (op != OP_SPECIAL);
		dec_zero_ext = 1'b0;
		dec_reg_write = 1'b0;
		dec_mem_read = 1'b0;
		dec_mem_write = 1'b0;
		uses_rt_decode = 1'b0;
		is_beq = 1'b0;
		is_bne = 1'b0;
		is_jr = 1'b0;
		case (op)
			OP_SPECIAL: begin
				case (funct)
					FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLTU: begin
						dec_reg_write = 1'b1;
						uses_rt_decode = 1'b1;
					end
					FN_JR: is_jr = 1'b1;
					default: ;
				endcase
				case (funct)
					FN_SUBU: dec_op = ALU_SUB;
					FN_AND:  dec_op = ALU_AND;
					FN_OR:   dec_op = ALU_OR;
					FN_XOR:  dec_op = ALU_XOR;
					FN_SLTU: dec_op = ALU_SLTU;
					default: dec_op = ALU_ADD;
				endcase
			end
			OP_ADDIU: dec_reg_write = 1'b1;
			OP_ANDI: begin
				dec_op = ALU_AND;
				dec_zero_ext = 1'b1;
				dec_reg_write = 1'b1;
			end
			OP_ORI: begin
				dec_op = ALU_OR;
				dec_zero_ext = 1'b1;
				dec_reg_write = 1'b1;
			end
			OP_XORI: begin
				dec_op = ALU_XOR;
				dec_zero_ext = 1'b1;
				dec_reg_write = 1'b1;
			end
			OP_LUI: begin
				dec_op = ALU_LUI;
				dec_reg_write = 1'b1;
			end
			OP_LW: begin
				dec_reg_write = 1'b1;
				dec_mem_read = 1'b1;
			end
			OP_SW: begin
				dec_mem_write = 1'b1;
				uses_rt_decode = 1'b1;
			end
			OP_BEQ: begin
				is_beq = 1'b1;
				uses_rt_decode = 1'b1;
			end
			OP_BNE: begin
				is_bne = 1'b1;
				uses_rt_decode = 1'b1;
			end
			default: ;
		endcase
	end

	assign ext_imm = dec_zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};

	// Register zero reads as zero, writeback data is passed straight through
	assign rd_a = (rs_decode == '0) ? '0 :
		(wb_write && wb_dest == rs_decode) ? wb_result : regs[rs_decode];
	assign rd_b = (rt_decode == '0) ? '0 :
		(wb_write && wb_dest == rt_decode) ? wb_result : regs[rt_decode];
	assign register_v0 = regs[`MIPS_REG_V0];

	always_ff @(posedge clk) begin
		if (advance && wb_write && wb_dest != '0)
			regs[wb_dest] <= wb_result;
	end

	// Branch compare with the memory-stage forward
	assign cmp_a = fwd_a_decode ? mem_alu_result : rd_a;
	assign cmp_b = fwd_b_decode ? mem_alu_result : rd_b;
	assign is_branch_decode = is_beq || is_bne || is_jr;
	assign branch_taken = is_jr || (is_beq && cmp_a == cmp_b) || (is_bne && cmp_a != cmp_b);
	assign branch_target = is_jr ? cmp_a : pc_plus4_decode + {ext_imm[29:0], 2'b00};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_reg_write <= 1'b0;
			ex_mem_read <= 1'b0;
			ex_mem_write <= 1'b0;
			ex_halt <= 1'b0;
		end else if (advance) begin
			ex_reg_write <= dec_reg_write && !bubble_execute;
			ex_mem_read <= dec_mem_read && !bubble_execute;
			ex_mem_write <= dec_mem_write && !bubble_execute;
			ex_halt <= halt_decode && !bubble_execute;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			ex_op <= dec_op;
			ex_a <= rd_a;
			ex_b <= rd_b;
			ex_imm <= ext_imm;
			ex_use_imm <= dec_use_imm;
			ex_rs <= rs_decode;
			ex_rt <= rt_decode;
			ex_dest <= dec_dest;
		end
	end

endmodule

// File: hw/execute_stage.sv
// Execute stage
// Operand forwarding, ALU and the execute/memory register

`timescale 1ns/10ps

module execute_stage (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    advance,
	input  mips_pipe_pkg::alu_op_t  ex_op,
	input  mips_pipe_pkg::word_t    ex_a,
	input  mips_pipe_pkg::word_t    ex_b,
	input  mips_pipe_pkg::word_t    ex_imm,
	input  logic                    ex_use_imm,
	input  mips_isa_pkg::reg_addr_t ex_dest,
	input  logic                    ex_reg_write,
	input  logic                    ex_mem_read,
	input  logic                    ex_mem_write,
	input  logic                    ex_halt,
	input  mips_pipe_pkg::fwd_sel_t fwd_a_exec,
	input  mips_pipe_pkg::fwd_sel_t fwd_b_exec,
	input  mips_pipe_pkg::word_t    wb_result,
	output logic                    mem_read,
	output logic                    mem_write,
	output logic                    mem_reg_write,
	output logic                    mem_halt,
	output mips_isa_pkg::reg_addr_t mem_dest,
	output mips_pipe_pkg::word_t    mem_alu_result,
	output mips_pipe_pkg::word_t    mem_addr,
	output mips_pipe_pkg::word_t    mem_store_data
);
	import mips_pipe_pkg::*;

	word_t op_a;
	word_t reg_b;
	word_t op_b;
	word_t alu_result;

	always_comb begin
		case (fwd_a_exec)
			FWD_FROM_MEM: op_a = mem_alu_result;
			FWD_FROM_WB:  op_a = wb_result;
			default:      op_a = ex_a;
		endcase
		case (fwd_b_exec)
			FWD_FROM_MEM: reg_b = mem_alu_result;
			FWD_FROM_WB:  reg_b = wb_result;
			default:      reg_b = ex_b;
		endcase
	end

	assign op_b = ex_use_imm ? ex_imm : reg_b;

	always_comb begin
		case (ex_op)
			ALU_SUB:  alu_result = op_a - op_b;
			ALU_AND:  alu_result = op_a & op_b;
			ALU_OR:   alu_result = op_a | op_b;
			ALU_XOR:  alu_result = op_a ^ op_b;
			ALU_SLTU: alu_result = word_t'(op_a < op_b);
			ALU_LUI:  alu_result = op_b << 16;
			default:  alu_result = op_a + op_b;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_read <= 1'b0;
			mem_write <= 1'b0;
			mem_reg_write <= 1'b0;
			mem_halt <= 1'b0;
		end else if (advance) begin
			mem_read <= ex_mem_read;
			mem_write <= ex_mem_write;
			mem_reg_write <= ex_reg_write;
			mem_halt <= ex_halt;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			mem_dest <= ex_dest;
			mem_alu_result <= alu_result;
			// Store data takes the forwarded rt value
			mem_store_data <= reg_b;
		end
	end

	assign mem_addr = mem_alu_result;

endmodule

// File: hw/writeback_stage.sv
// Writeback stage
// Memory/writeback register, result select and the halt flag behind active

`timescale 1ns/10ps

module writeback_stage (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    advance,
	input  logic                    mem_read,
	input  logic                    mem_reg_write,
	input  logic                    mem_halt,
	input  mips_isa_pkg::reg_addr_t mem_dest,
	input  mips_pipe_pkg::word_t    mem_alu_result,
	input  mips_pipe_pkg::word_t    load_data,
	output logic                    wb_write,
	output mips_isa_pkg::reg_addr_t wb_dest,
	output mips_pipe_pkg::word_t    wb_result,
	output logic                    active
);
	import mips_pipe_pkg::*;

	logic  wb_is_load;
	logic  wb_halted;
	word_t wb_alu;
	word_t wb_load;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_write <= 1'b0;
			wb_halted <= 1'b0;
		end else if (advance) begin
			wb_write <= mem_reg_write;
			// Sticky until reset
			if (mem_halt)
				wb_halted <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			wb_dest <= mem_dest;
			wb_is_load <= mem_read;
			wb_alu <= mem_alu_result;
			wb_load <= load_data;
		end
	end

	assign wb_result = wb_is_load ? wb_load : wb_alu;
	assign active = !wb_halted;

endmodule

// File: hw/hazard_unit.sv
// Hazard unit
// Forwarding selects and the stall and bubble decisions for the front end

`timescale 1ns/10ps

module hazard_unit (
	input  mips_isa_pkg::reg_addr_t rs_decode,
	input  mips_isa_pkg::reg_addr_t rt_decode,
	input  mips_isa_pkg::reg_addr_t ex_rs,
	input  mips_isa_pkg::reg_addr_t ex_rt,
	input  mips_isa_pkg::reg_addr_t ex_dest,
	input  mips_isa_pkg::reg_addr_t mem_dest,
	input  mips_isa_pkg::reg_addr_t wb_dest,
	input  logic                    uses_rt_decode,
	input  logic                    is_branch_decode,
	input  logic                    ex_reg_write,
	input  logic                    ex_mem_read,
	input  logic                    mem_reg_write,
	input  logic                    mem_read,
	input  logic                    wb_write,
	output logic                    stall_front,
	output logic                    bubble_execute,
	output logic                    fwd_a_decode,
	output logic                    fwd_b_decode,
	output mips_pipe_pkg::fwd_sel_t fwd_a_exec,
	output mips_pipe_pkg::fwd_sel_t fwd_b_exec
);
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;

	logic load_use;
	logic branch_dep;

	// A written register other than zero matches a source
	function automatic logic hit(input logic we, input reg_addr_t dest, input reg_addr_t src);
		return we && dest != '0 && dest == src;
	endfunction

	function automatic fwd_sel_t pick(input reg_addr_t src, input logic mem_we,
			input reg_addr_t mem_d, input logic wb_we, input reg_addr_t wb_d);
		if (hit(mem_we, mem_d, src))
			return FWD_FROM_MEM;
		if (hit(wb_we, wb_d, src))
			return FWD_FROM_WB;
		return FWD_REG;
	endfunction

	always_comb begin
		load_use = hit(ex_mem_read, ex_dest, rs_decode)
			|| (uses_rt_decode && hit(ex_mem_read, ex_dest, rt_decode));
		branch_dep = is_branch_decode && (hit(ex_reg_write, ex_dest, rs_decode)
			|| (uses_rt_decode && hit(ex_reg_write, ex_dest, rt_decode))
			|| hit(mem_read, mem_dest, rs_decode)
			|| (uses_rt_decode && hit(mem_read, mem_dest, rt_decode)));
		fwd_a_exec = pick(ex_rs, mem_reg_write, mem_dest, wb_write, wb_dest);
		fwd_b_exec = pick(ex_rt, mem_reg_write, mem_dest, wb_write, wb_dest);
	end

	assign stall_front = load_use || branch_dep;
	assign bubble_execute = stall_front;

	// Loads in memory stall instead, so only ALU results reach the comparator
	assign fwd_a_decode = hit(mem_reg_write && !mem_read, mem_dest, rs_decode);
	assign fwd_b_decode = hit(mem_reg_write && !mem_read, mem_dest, rt_decode);

endmodule

// File: hw/bus_controller.sv
// Shared Avalon-MM master sequencer
// One instruction fetch then at most one data access per round, then an advance pulse

`timescale 1ns/10ps

module bus_controller (
	input  logic                 clk,
	input  logic                 rst_n,
	input  mips_pipe_pkg::word_t pc,
	input  logic                 fetch_enabled,
	input  logic                 mem_read,
	input  logic                 mem_write,
	input  mips_pipe_pkg::word_t mem_addr,
	input  mips_pipe_pkg::word_t mem_store_data,
	input  logic                 waitrequest,
	input  mips_pipe_pkg::word_t readdata,
	output mips_pipe_pkg::word_t address,
	output mips_pipe_pkg::word_t writedata,
	output logic                 read,
	output logic                 write,
	output logic [3:0]           byteenable,
	output logic                 advance,
	output mips_pipe_pkg::word_t fetched_instr,
	output mips_pipe_pkg::word_t load_data
);
	import mips_pipe_pkg::*;

	bus_state_t state;
	logic       data_access;
	logic       fetch_done;
	logic       data_done;

	assign data_access = mem_read || mem_write;
	assign fetch_done = state == BUS_FETCH && fetch_enabled && !waitrequest;
	assign data_done = state == BUS_DATA && data_access && !waitrequest;

	// Request lines depend only on state and pipeline registers, so they hold under waitrequest
	assign read = (state == BUS_FETCH && fetch_enabled) || (state == BUS_DATA && mem_read);
	assign write = state == BUS_DATA && mem_write;
	assign address = (state == BUS_DATA) ? mem_addr : pc;
	assign writedata = mem_store_data;
	assign byteenable = 4'b1111;
	assign advance = state == BUS_STEP;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= BUS_FETCH;
		end else begin
			case (state)
				BUS_FETCH: begin
					if (!fetch_enabled)
						state <= BUS_DATA;
					else if (fetch_done)
						state <= data_access ? BUS_DATA : BUS_STEP;
				end
				BUS_DATA: begin
					if (!data_access || data_done)
						state <= BUS_STEP;
				end
				default: state <= BUS_FETCH;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_done)
			fetched_instr <= readdata;
		if (data_done && mem_read)
			load_data <= readdata;
	end

endmodule

// File: hw/mips_cpu_bus.sv
// Pipelined MIPS-I subset core with one shared Avalon-MM master port
// Connects the five stages, the hazard unit and the bus sequencer

`timescale 1ns/10ps

module mips_cpu_bus (
	input  logic                 clk,
	input  logic                 rst_n,
	output logic                 active,
	output mips_pipe_pkg::word_t register_v0,
	output mips_pipe_pkg::word_t address,
	output logic                 write,
	output logic                 read,
	input  logic                 waitrequest,
	output mips_pipe_pkg::word_t writedata,
	output logic [3:0]           byteenable,
	input  mips_pipe_pkg::word_t readdata
);
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;

	// Round control
	logic      advance;
	logic      stall_front;
	logic      bubble_execute;
	word_t     fetched_instr;
	word_t     load_data;

	// Fetch and decode
	word_t     pc;
	logic      fetch_enabled;
	logic      branch_taken;
	word_t     branch_target;
	instr_t    instr_decode;
	word_t     pc_plus4_decode;
	logic      halt_decode;
	reg_addr_t rs_decode;
	reg_addr_t rt_decode;
	logic      uses_rt_decode;
	logic      is_branch_decode;
	logic      fwd_a_decode;
	logic      fwd_b_decode;

	// Execute
	alu_op_t   ex_op;
	word_t     ex_a;
	word_t     ex_b;
	word_t     ex_imm;
	logic      ex_use_imm;
	reg_addr_t ex_rs;
	reg_addr_t ex_rt;
	reg_addr_t ex_dest;
	logic      ex_reg_write;
	logic      ex_mem_read;
	logic      ex_mem_write;
	logic      ex_halt;
	fwd_sel_t  fwd_a_exec;
	fwd_sel_t  fwd_b_exec;

	// Memory and writeback
	logic      mem_read;
	logic      mem_write;
	logic      mem_reg_write;
	logic      mem_halt;
	reg_addr_t mem_dest;
	word_t     mem_alu_result;
	word_t     mem_addr;
	word_t     mem_store_data;
	logic      wb_write;
	reg_addr_t wb_dest;
	word_t     wb_result;

	fetch_unit      u_fetch (.*);
	decode_stage    u_decode (.*);
	execute_stage   u_execute (.*);
	writeback_stage u_writeback (.*);
	hazard_unit     u_hazard (.*);
	bus_controller  u_bus (.*);

endmodule

// File: verif/mips_cpu_bus_assert.sv
// Bus protocol and reset checks for the MIPS core
// Bound to the core top level

`timescale 1ns/10ps

module mips_cpu_bus_assert (
	input logic        clk,
	input logic        rst_n,
	input logic        active,
	input logic [31:0] address,
	input logic        write,
	input logic        read,
	input logic        waitrequest,
	input logic [31:0] writedata,
	input logic [3:0]  byteenable
);

	// One request at a time on the shared port
	a_one_request: assert property (@(posedge clk) disable iff (!rst_n)
		!(read && write))
		else $error("read and write are both high");

	a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		(read || write) |-> address[1:0] == 2'b00)
		else $error("request address is not word aligned");

	a_full_word: assert property (@(posedge clk) disable iff (!rst_n)
		(read || write) |-> byteenable == 4'b1111)
		else $error("byteenable is not all ones during a request");

	// Request held steady under wait states
	a_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(read || write) && waitrequest |=>
		$stable(address) && $stable(write) && $stable(writedata))
		else $error("request changed while waitrequest was high");

	a_active_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> active)
		else $error("active is low right after reset release");

endmodule

bind mips_cpu_bus mips_cpu_bus_assert u_bus_assert (
	.clk(clk),
	.rst_n(rst_n),
	.active(active),
	.address(address),
	.write(write),
	.read(read),
	.waitrequest(waitrequest),
	.writedata(writedata),
	.byteenable(byteenable)
);

// File: verif/mips_cpu_bus_tb.sv
// Testbench for the pipelined MIPS core on its shared Avalon-MM port
// Memory model with optional wait states, reference interpreter and store checks

`timescale 1ns/10ps

`include "mips_defines.svh"

module mips_cpu_bus_tb;

	localparam logic [5:0] OP_BEQ = 6'h04;
	localparam logic [5:0] OP_BNE = 6'h05;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_ANDI = 6'h0c;
	localparam logic [5:0] OP_ORI = 6'h0d;
	localparam logic [5:0] OP_XORI = 6'h0e;
	localparam logic [5:0] OP_LUI = 6'h0f;
	localparam logic [5:0] OP_LW = 6'h23;
	localparam logic [5:0] OP_SW = 6'h2b;
	localparam logic [5:0] FN_JR = 6'h08;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_XOR = 6'h26;
	localparam logic [5:0] FN_SLTU = 6'h2b;
	localparam logic [31:0] LFSR_SEED = 32'h4062_ab18;
	localparam int HALT_TIMEOUT = 5000;
	localparam int QUIET_CYCLES = 40;

	logic        clk;
	logic        rst_n;
	logic        active;
	logic [31:0] register_v0;
	logic [31:0] address;
	logic        write;
	logic        read;
	logic        waitrequest;
	logic [31:0] writedata;
	logic [3:0]  byteenable;
	logic [31:0] readdata;

	logic [31:0] init_mem [logic [31:0]];
	logic [31:0] dut_mem [logic [31:0]];
	logic [31:0] ref_mem [logic [31:0]];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [31:0] got_addr [$];
	logic [31:0] got_data [$];
	logic [31:0] lfsr;
	logic        random_wait;
	int          load_ptr;
	int          checked;
	int          late_access;
	int          err_value;
	int          err_other;

	mips_cpu_bus UUT (
		.clk(clk),
		.rst_n(rst_n),
		.active(active),
		.register_v0(register_v0),
		.address(address),
		.write(write),
		.read(read),
		.waitrequest(waitrequest),
		.writedata(writedata),
		.byteenable(byteenable),
		.readdata(readdata)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] fill_word(input logic [31:0] a);
		return {a[15:0], a[31:16]} ^ 32'h6b5e_0c3d;
	endfunction

	function automatic logic [31:0] reference_word(input logic [31:0] a);
		if (ref_mem.exists(a))
			return ref_mem[a];
		return fill_word(a);
	endfunction

	function automatic logic [31:0] memory_word(input logic [31:0] a);
		if (dut_mem.exists(a))
			return dut_mem[a];
		return fill_word(a);
	endfunction

	function automatic logic [31:0] r_format(input logic [5:0] fn, input logic [4:0] rs,
			input logic [4:0] rt, input logic [4:0] rd);
		return {6'h00, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] i_format(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// ISA-level model with delay slots, stops when control reaches address zero
	function automatic logic [31:0] reference_run();
		logic [31:0] regs [32];
		logic [31:0] pc;
		logic [31:0] npc;
		logic [31:0] target;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] simm;
		logic [31:0] zimm;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic        taken;
		int          steps;
		for (steps = 0; steps < 32; steps++)
			regs[steps] = '0;
		ref_mem = init_mem;
		exp_addr.delete();
		exp_data.delete();
		pc = `MIPS_RESET_VECTOR;
		npc = pc + 4;
		steps = 0;
		while (pc != '0 && steps < 1000) begin
			ins = reference_word(pc);
			rs = ins[25:21];
			rt = ins[20:16];
			rd = ins[15:11];
			a = regs[rs];
			b = regs[rt];
			simm = {{16{ins[15]}}, ins[15:0]};
			zimm = {16'h0000, ins[15:0]};
			taken = 1'b0;
			target = npc + {simm[29:0], 2'b00};
			case (ins[31:26])
				6'h00: begin
					case (ins[5:0])
						FN_ADDU: regs[rd] = a + b;
						FN_SUBU: regs[rd] = a - b;
						FN_AND:  regs[rd] = a & b;
						FN_OR:   regs[rd] = a | b;
						FN_XOR:  regs[rd] = a ^ b;
						FN_SLTU: regs[rd] = {31'd0, a < b};
						FN_JR: begin
							taken = 1'b1;
							target = a;
						end
						default: ;
					endcase
				end
				OP_ADDIU: regs[rt] = a + simm;
				OP_ANDI:  regs[rt] = a & zimm;
				OP_ORI:   regs[rt] = a | zimm;
				OP_XORI:  regs[rt] = a ^ zimm;
				OP_LUI:   regs[rt] = {ins[15:0], 16'h0000};
				OP_LW:    regs[rt] = reference_word(a + simm);
				OP_SW: begin
					ref_mem[a + simm] = b;
					exp_addr.push_back(a + simm);
					exp_data.push_back(b);
				end
				OP_BEQ: taken = (a == b);
				OP_BNE: taken = (a != b);
				default: ;
			endcase
			regs[0] = '0;
			pc = npc;
			npc = taken ? target : npc + 4;
			steps++;
		end
		return regs[2];
	endfunction

	task automatic program_word(input logic [31:0] w);
		init_mem[`MIPS_RESET_VECTOR + load_ptr * `MIPS_WORD_BYTES] = w;
		load_ptr++;
	endtask

	// Dependent ALU chain, load-use and load-store pairs
	task automatic load_alu_program();
		init_mem.delete();
		load_ptr = 0;
		program_word(i_format(OP_ADDIU, 5'd0, 5'd1, 16'h1234));
		program_word(i_format(OP_ADDIU, 5'd1, 5'd2, 16'h0011));
		program_word(i_format(OP_LUI, 5'd0, 5'd3, 16'h8000));
		program_word(r_format(FN_ADDU, 5'd2, 5'd1, 5'd4));
		program_word(r_format(FN_SUBU, 5'd4, 5'd3, 5'd5));
		program_word(r_format(FN_AND, 5'd5, 5'd2, 5'd6));
		program_word(r_format(FN_OR, 5'd6, 5'd3, 5'd7));
		program_word(r_format(FN_XOR, 5'd7, 5'd5, 5'd8));
		program_word(r_format(FN_SLTU, 5'd3, 5'd8, 5'd9));
		program_word(i_format(OP_ANDI, 5'd8, 5'd10, 16'hff0f));
		program_word(i_format(OP_ORI, 5'd10, 5'd11, 16'h8001));
		program_word(i_format(OP_XORI, 5'd11, 5'd12, 16'hffff));
		program_word(i_format(OP_SW, 5'd0, 5'd12, 16'h0100));
		program_word(i_format(OP_LW, 5'd0, 5'd13, 16'h0100));
		program_word(r_format(FN_ADDU, 5'd13, 5'd9, 5'd2));
		program_word(i_format(OP_SW, 5'd0, 5'd2, 16'h0104));
		program_word(i_format(OP_LW, 5'd0, 5'd14, 16'h0108));
		program_word(i_format(OP_SW, 5'd0, 5'd14, 16'h010c));
		program_word(r_format(FN_ADDU, 5'd2, 5'd14, 5'd2));
		program_word(r_format(FN_JR, 5'd0, 5'd0, 5'd0));
		program_word(i_format(OP_ADDIU, 5'd2, 5'd2, 16'h0001));
		program_word(i_format(OP_ADDIU, 5'd2, 5'd2, 16'h0100));
		init_mem[32'h0000_0108] = 32'h1357_9bdf;
	endtask

	// Counted BNE loop, then BEQ on a freshly loaded word
	task automatic load_loop_program();
		init_mem.delete();
		load_ptr = 0;
		program_word(i_format(OP_ADDIU, 5'd0, 5'd1, 16'h0005));
		program_word(i_format(OP_ADDIU, 5'd0, 5'd2, 16'h0000));
		program_word(i_format(OP_ADDIU, 5'd0, 5'd4, 16'h0200));
		program_word(r_format(FN_ADDU, 5'd2, 5'd1, 5'd2));
		program_word(i_format(OP_SW, 5'd4, 5'd2, 16'h0000));
		program_word(i_format(OP_ADDIU, 5'd1, 5'd1, 16'hffff));
		program_word(i_format(OP_BNE, 5'd1, 5'd0, 16'hfffc));
		program_word(i_format(OP_ADDIU, 5'd4, 5'd4, 16'h0004));
		program_word(i_format(OP_LW, 5'd4, 5'd5, 16'hfffc));
		program_word(i_format(OP_BEQ, 5'd5, 5'd2, 16'h0002));
		program_word(i_format(OP_ADDIU, 5'd2, 5'd2, 16'h0007));
		program_word(i_format(OP_ADDIU, 5'd2, 5'd2, 16'h0040));
		program_word(i_format(OP_SW, 5'd4, 5'd2, 16'h0000));
		program_word(r_format(FN_JR, 5'd0, 5'd0, 5'd0));
		program_word(i_format(OP_XORI, 5'd2, 5'd2, 16'h005a));
		program_word(i_format(OP_ADDIU, 5'd0, 5'd2, 16'h0000));
	endtask

	// Slave decisions made on the falling edge for the next rising edge
	always @(negedge clk) begin
		logic stall_now;
		stall_now = 1'b0;
		if (random_wait) begin
			lfsr = lfsr_step(lfsr);
			stall_now = lfsr[0];
		end
		waitrequest = stall_now;
		if (rst_n && !active && (read || write))
			late_access++;
		if (!stall_now && read)
			readdata = memory_word(address);
		if (rst_n && !stall_now && write) begin
			dut_mem[address] = writedata;
			got_addr.push_back(address);
			got_data.push_back(writedata);
		end
	end

	// Store checker
	always @(posedge clk) begin
		if (checked < got_addr.size()) begin
			if (checked >= exp_addr.size()) begin
				$display("Unexpected extra store of %h to %h at %0t",
					got_data[checked], got_addr[checked], $time);
				err_other++;
			end else if (got_addr[checked] !== exp_addr[checked]
					|| got_data[checked] !== exp_data[checked]) begin
				$display("ERR %0t store %0d wrote %h to %h, expected %h to %h", $time, checked,
					got_data[checked], got_addr[checked], exp_data[checked], exp_addr[checked]);
				err_value++;
			end
			checked++;
		end
	end

	task automatic run_program(input logic with_waits, input string name,
			output logic timed_out);
		logic [31:0] exp_v0;
		logic [31:0] v0_at_halt;
		int          cycles;
		exp_v0 = reference_run();
		dut_mem = init_mem;
		got_addr.delete();
		got_data.delete();
		checked = 0;
		late_access = 0;
		timed_out = 1'b0;
		@(negedge clk);
		rst_n = 1'b0;
		@(posedge clk);
		lfsr = LFSR_SEED;
		random_wait = with_waits;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		cycles = 0;
		while (active && cycles < HALT_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (active) begin
			$display("Timeout: %s program did not halt within %0d cycles", name, cycles);
			err_other++;
			timed_out = 1'b1;
		end else begin
			v0_at_halt = register_v0;
			if (v0_at_halt !== exp_v0) begin
				$display("ERR %0t %s: register_v0 is %h, expected %h", $time, name,
					v0_at_halt, exp_v0);
				err_value++;
			end
			// Halted core must stay quiet and hold its state
			repeat (QUIET_CYCLES) @(negedge clk);
			if (late_access != 0) begin
				$display("The %s program made %0d bus requests after halting", name, late_access);
				err_other++;
			end
			if (register_v0 !== v0_at_halt) begin
				$display("ERR %0t %s: register_v0 moved to %h after halt", $time, name,
					register_v0);
				err_value++;
			end
			if (active) begin
				$display("The %s program raised active again after halting", name);
				err_other++;
			end
			if (got_addr.size() != exp_addr.size()) begin
				$display("The %s program made %0d stores, the reference made %0d", name,
					got_addr.size(), exp_addr.size());
				err_other++;
			end
		end
	endtask

	initial begin
		logic stop;
		int   mode;
		rst_n = 1'b0;
		waitrequest = 1'b0;
		readdata = '0;
		random_wait = 1'b0;
		lfsr = LFSR_SEED;
		checked = 0;
		late_access = 0;
		err_value = 0;
		err_other = 0;
		stop = 1'b0;
		// Mode 0 ties waitrequest low, mode 1 draws it from the LFSR
		for (mode = 0; mode < 2; mode++) begin
			if (!stop) begin
				load_alu_program();
				run_program(mode == 1, "alu", stop);
			end
			if (!stop) begin
				load_loop_program();
				run_program(mode == 1, "loop", stop);
			end
		end
		$display("Errors: %0d wrong values, %0d other failures", err_value, err_other);
		if (err_value == 0 && err_other == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// File: mips_cpu_bus.f
+incdir+hw
hw/mips_isa_pkg.sv
hw/mips_pipe_pkg.sv
hw/fetch_unit.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/writeback_stage.sv
hw/hazard_unit.sv
hw/bus_controller.sv
hw/mips_cpu_bus.sv
verif/mips_cpu_bus_assert.sv
verif/mips_cpu_bus_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the MIPS core testbench with Verilator
set -euo pipefail

cd "$(dirname "$0")"
LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -j 0 \
	--top-module mips_cpu_bus_tb --Mdir "$BUILD" \
	-f mips_cpu_bus.f

"./$BUILD/Vmips_cpu_bus_tb" | tee "$LOG"

if grep -q "STATUS: FAIL" "$LOG"; then
	echo "Simulation reported failures, see $LOG"
	exit 1
fi
echo "Simulation finished without failures"
